// File: design/obj_config.svh
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// Entries in the object table
`define OBJ_COUNT 64

// Table word address, four words per entry
`define OBJ_TBL_AW 8

// Graphics ROM address in 32-bit words
`define OBJ_ROM_AW 18

// Line buffer address, one half
`define OBJ_LINE_AW 9

// Object width in pixels
`define OBJ_WIDTH 16

`endif

// File: design/obj_pkg.sv
// Object table entry, four 16-bit words
//   word 0: top line [15:8], height [7:0]
//           zero height ends the list
//   word 1: hflip [15], prio [14:13], pal [12:9], xpos [8:0]
//   word 2: ROM base address in 32-bit words
//   word 3: unused
// Each row of an object is two ROM words, pixel 0 in bits 31..28
package obj_pkg;

    // Attributes taken from word 1
    typedef struct packed {
        logic [1:0] prio;
        logic [3:0] pal;
        logic       hflip;
    } obj_attr_t;

    // One line buffer location
    // color 0 is transparent
    typedef struct packed {
        logic [1:0] prio;
        logic [3:0] pal;
        logic [3:0] color;
    } obj_pixel_t;

endpackage

// File: design/obj_draw_if.sv
`include "obj_config.svh"

// Draw commands from scan stage to draw stage
interface obj_draw_if;
    // One-cycle strobe, fields valid with it
    logic                   start;
    // High from the cycle after start to the last pixel write
    logic                   busy;
    logic [`OBJ_LINE_AW-1:0] xpos;
    // Base plus row offset already applied
    logic [`OBJ_ROM_AW-1:0] rom_addr;
    obj_pkg::obj_attr_t     attr;

    modport scan (
        output start,
        output xpos,
        output rom_addr,
        output attr,
        input  busy
    );

    modport draw (
        input  start,
        input  xpos,
        input  rom_addr,
        input  attr,
        output busy
    );
endinterface

// File: design/obj_table_ram.sv
`include "obj_config.svh"

module obj_table_ram (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   swap,
    // CPU side
    input  logic                   cpu_cs,
    input  logic                   cpu_we,
    input  logic [`OBJ_TBL_AW-1:0] cpu_addr,
    input  logic [15:0]            cpu_dout,
    output logic [15:0]            cpu_din,
    // Scan side
    input  logic [`OBJ_TBL_AW-1:0] tbl_addr,
    output logic [15:0]            tbl_dout
);

    localparam int BANK_WORDS = 1 << `OBJ_TBL_AW;

    // Both banks in one array, bank number is the top address bit
    logic [15:0] mem [0:2*BANK_WORDS-1];

    // Bank owned by the CPU, scan gets the other one
    logic bank;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank <= 1'b0;
        end else if (swap) begin
            bank <= ~bank;
        end
    end

    always_ff @(posedge clk) begin
        // Whole-word CPU writes
        if (cpu_cs && cpu_we) begin
            mem[{bank, cpu_addr}] <= cpu_dout;
        end
        // Readback shows the old word on a write cycle
        if (cpu_cs) begin
            cpu_din <= mem[{bank, cpu_addr}];
        end
        // Scan read, one cycle latency
        tbl_dout <= mem[{~bank, tbl_addr}];
    end

endmodule

// File: design/obj_scan.sv
`include "obj_config.svh"

module obj_scan (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hstart,
    input  logic [8:0]             vrender,
    // Table read port
    output logic [`OBJ_TBL_AW-1:0] tbl_addr,
    input  logic [15:0]            tbl_dout,
    // Draw commands
    obj_draw_if.scan               dr
);

    localparam int EW = $clog2(`OBJ_COUNT);

    // W0..W2 present word addresses, data trails by one state
    typedef enum logic [2:0] {
        S_IDLE,
        S_W0,
        S_W1,
        S_W2,
        S_W3,
        S_ISSUE
    } state_t;

    state_t             state;
    logic [EW-1:0]      entry;
    logic [1:0]         word;
    logic               last_entry;
    logic [8:0]         vline;
    logic [8:0]         row;
    logic               visible;
    logic [7:0]         row_r;
    logic [`OBJ_LINE_AW-1:0] xpos_r;
    obj_pkg::obj_attr_t attr_r;
    logic [`OBJ_ROM_AW-1:0] rom_addr_r;

    // Word index follows the state
    always_comb begin
        case (state)
            S_W1:    word = 2'd1;
            S_W2:    word = 2'd2;
            default: word = 2'd0;
        endcase
    end

    assign tbl_addr   = {entry, word};
    assign last_entry = entry == EW'(`OBJ_COUNT - 1);

    // Row inside the object, wraps high when line is above top
    assign row     = vline - {1'b0, tbl_dout[15:8]};
    assign visible = row < {1'b0, tbl_dout[7:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            entry <= '0;
        end else if (hstart) begin
            // New line, unfinished work is dropped
            state <= S_W0;
            entry <= '0;
        end else begin
            case (state)
                S_W0: state <= S_W1;
                S_W1: begin
                    // Word 0 on tbl_dout here
                    if (tbl_dout[7:0] == 8'd0) begin
                        state <= S_IDLE;
                    end else if (visible) begin
                        state <= S_W2;
                    end else if (last_entry) begin
                        state <= S_IDLE;
                    end else begin
                        entry <= entry + 1'b1;
                        state <= S_W0;
                    end
                end
                S_W2: state <= S_W3;
                S_W3: state <= S_ISSUE;
                S_ISSUE: begin
                    // Hold until draw stage is free
                    if (!dr.busy) begin
                        if (last_entry) begin
                            state <= S_IDLE;
                        end else begin
                            entry <= entry + 1'b1;
                            state <= S_W0;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Command fields
    always_ff @(posedge clk) begin
        // Line to render, fixed for the whole walk
        if (hstart) begin
            vline <= vrender;
        end
        if (state == S_W1) begin
            row_r <= row[7:0];
        end
        // Word 1 fields
        if (state == S_W2) begin
            xpos_r       <= tbl_dout[`OBJ_LINE_AW-1:0];
            attr_r.pal   <= tbl_dout[12:9];
            attr_r.prio  <= tbl_dout[14:13];
            attr_r.hflip <= tbl_dout[15];
        end
        // Word 2 base plus two words per row
        if (state == S_W3) begin
            rom_addr_r <= `OBJ_ROM_AW'(tbl_dout) + `OBJ_ROM_AW'({row_r, 1'b0});
        end
    end

    // Never issue on hstart, the buffer halves swap that cycle
    assign dr.start    = (state == S_ISSUE) && !dr.busy && !hstart;
    assign dr.xpos     = xpos_r;
    assign dr.attr     = attr_r;
    assign dr.rom_addr = rom_addr_r;

endmodule

// File: design/obj_draw.sv
`include "obj_config.svh"

module obj_draw (
    input  logic                    clk,
    input  logic                    rst_n,
    // Commands from scan
    obj_draw_if.draw                dr,
    // Graphics ROM
    output logic                    rom_cs,
    output logic [`OBJ_ROM_AW-1:0]  rom_addr,
    input  logic                    rom_ok,
    input  logic [31:0]             rom_data,
    // Line buffer write port
    output logic                    buf_we,
    output logic [`OBJ_LINE_AW-1:0] buf_addr,
    output obj_pkg::obj_pixel_t     buf_data
);

    localparam int CW = $clog2(`OBJ_WIDTH);
    localparam int GW = 4 * `OBJ_WIDTH;

    // GAP drops rom_cs for a cycle between the two fetches
    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_GAP,
        D_WRITE
    } state_t;

    state_t                  state;
    // Which of the two words is being fetched
    logic                    wsel;
    logic [CW-1:0]           cnt;
    logic [`OBJ_LINE_AW-1:0] xpos_r;
    logic [`OBJ_ROM_AW-1:0]  addr_r;
    obj_pkg::obj_attr_t      attr_r;
    // Both words, first fetched in the upper half
    logic [GW-1:0]           gfx;
    logic [3:0]              color;
    logic [CW-1:0]           offs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= D_IDLE;
            wsel  <= 1'b0;
            cnt   <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (dr.start) begin
                        state <= D_FETCH;
                        wsel  <= 1'b0;
                    end
                end
                D_FETCH: begin
                    // Address held until the ROM answers
                    if (rom_ok) begin
                        if (wsel) begin
                            state <= D_WRITE;
                            cnt   <= '0;
                        end else begin
                            state <= D_GAP;
                            wsel  <= 1'b1;
                        end
                    end
                end
                D_GAP: state <= D_FETCH;
                D_WRITE: begin
                    // One pixel per cycle
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(`OBJ_WIDTH - 1)) begin
                        state <= D_IDLE;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Latch command on accept
        if (state == D_IDLE && dr.start) begin
            xpos_r <= dr.xpos;
            addr_r <= dr.rom_addr;
            attr_r <= dr.attr;
        end
        if (state == D_FETCH && rom_ok) begin
            gfx <= {gfx[GW-33:0], rom_data};
        end
    end

    assign dr.busy  = state != D_IDLE;
    assign rom_cs   = state == D_FETCH;
    assign rom_addr = addr_r + `OBJ_ROM_AW'(wsel);

    // Pixel 0 is the top nibble of the first word
    assign color = gfx[GW - 1 - 4 * cnt -: 4];
    // Mirror about the object when flipped
    assign offs  = attr_r.hflip ? ~cnt : cnt;

    // Transparent pixels leave the buffer alone
    assign buf_we         = (state == D_WRITE) && (color != 4'd0);
    // Wraps at the end of the line
    assign buf_addr       = xpos_r + `OBJ_LINE_AW'(offs);
    assign buf_data.prio  = attr_r.prio;
    assign buf_data.pal   = attr_r.pal;
    assign buf_data.color = color;

endmodule

// File: design/obj_line_buffer.sv
`include "obj_config.svh"

module obj_line_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    hstart,
    input  logic                    lhbl,
    input  logic                    pxl_cen,
    // Draw side, back half
    input  logic                    we,
    input  logic [`OBJ_LINE_AW-1:0] wr_addr,
    input  obj_pkg::obj_pixel_t     wr_data,
    // Video side, front half
    output obj_pkg::obj_pixel_t     pxl
);

    localparam int HALF = 1 << `OBJ_LINE_AW;

    // Both halves, half number is the top address bit
    obj_pkg::obj_pixel_t mem [0:2*HALF-1];

    // Front half select, back half is the other one
    logic                    half;
    logic [`OBJ_LINE_AW-1:0] rd_cnt;
    logic                    rd;

    // Active pixel read
    assign rd = pxl_cen && lhbl;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half   <= 1'b0;
            rd_cnt <= '0;
            pxl    <= '0;
        end else begin
            if (hstart) begin
                half   <= ~half;
                rd_cnt <= '0;
            end else if (rd) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (rd) begin
                pxl <= mem[{half, rd_cnt}];
            end
        end
    end

    // Halves never collide, write and erase can share a cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[{~half, wr_addr}] <= wr_data;
        end
        // Erase as read, ready for the line after next
        if (rd) begin
            mem[{half, rd_cnt}] <= '0;
        end
    end

endmodule

// File: design/obj_engine.sv
`include "obj_config.svh"

module obj_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  logic                   obj_swap,
    // CPU port
    input  logic                   cpu_cs,
    input  logic                   cpu_we,
    input  logic [`OBJ_TBL_AW-1:0] cpu_addr,
    input  logic [15:0]            cpu_dout,
    output logic [15:0]            cpu_din,
    // Graphics ROM
    input  logic                   rom_ok,
    output logic                   rom_cs,
    output logic [`OBJ_ROM_AW-1:0] rom_addr,
    input  logic [31:0]            rom_data,
    // Video timing
    input  logic                   hstart,
    input  logic                   lhbl,
    input  logic [8:0]             vrender,
    output logic [9:0]             pxl
);

    // Scan to table
    logic [`OBJ_TBL_AW-1:0]  tbl_addr;
    logic [15:0]             tbl_dout;

    // Draw to line buffer
    logic                    buf_we;
    logic [`OBJ_LINE_AW-1:0] buf_addr;
    logic [9:0]              buf_data;

    obj_draw_if dr_if ();

    obj_table_ram u_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .swap     (obj_swap),
        .cpu_cs   (cpu_cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_din  (cpu_din),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk      (clk),
        .rst_n    (rst_n),
        .hstart   (hstart),
        .vrender  (vrender),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout),
        .dr       (dr_if.scan)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst_n    (rst_n),
        .dr       (dr_if.draw),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data)
    );

    obj_line_buffer u_line (
        .clk      (clk),
        .rst_n    (rst_n),
        .hstart   (hstart),
        .lhbl     (lhbl),
        .pxl_cen  (pxl_cen),
        .we       (buf_we),
        .wr_addr  (buf_addr),
        .wr_data  (buf_data),
        .pxl      (pxl)
    );

endmodule

// File: tests/obj_engine_tb.sv
`include "obj_config.svh"

module obj_engine_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_CYCLES = 1000;
    localparam int VIS_PIXELS  = 320;

    // DUT inputs
    logic                   clk      = 1'b0;
    logic                   rst_n    = 1'b0;
    logic                   pxl_cen  = 1'b0;
    logic                   obj_swap = 1'b0;
    logic                   cpu_cs   = 1'b0;
    logic                   cpu_we   = 1'b0;
    logic [`OBJ_TBL_AW-1:0] cpu_addr = '0;
    logic [15:0]            cpu_dout = '0;
    logic                   rom_ok   = 1'b0;
    logic [31:0]            rom_data = '0;
    logic                   hstart   = 1'b0;
    logic                   lhbl     = 1'b0;
    logic [8:0]             vrender  = '0;
    // DUT outputs
    logic [15:0]            cpu_din;
    logic                   rom_cs;
    logic [`OBJ_ROM_AW-1:0] rom_addr;
    obj_pkg::obj_pixel_t    pxl;

    // Video timing state
    logic                   video_on = 1'b0;
    int                     hcnt     = LINE_CYCLES - 1;
    int                     line_cnt = 0;
    logic [8:0]             vnext    = '0;
    obj_pkg::obj_pixel_t    cap [0:VIS_PIXELS-1];
    int                     cap_cnt  = 0;

    // Copy of both table banks indexed by {bank, word}
    logic [15:0]            shadow [0:511];
    logic                   cpu_bank = 1'b0;
    obj_pkg::obj_pixel_t    exp_line [0:511];

    // Cycles left before the ROM answers
    int                     rom_left = 0;
    // Address of the open ROM request
    logic [`OBJ_ROM_AW-1:0] req_addr = '0;
    int                     err_cnt  = 0;
    int                     to_cnt   = 0;

    obj_engine obj_engine_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .obj_swap (obj_swap),
        .cpu_cs   (cpu_cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_din  (cpu_din),
        .rom_ok   (rom_ok),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .hstart   (hstart),
        .lhbl     (lhbl),
        .vrender  (vrender),
        .pxl      (pxl)
    );

    always #20 clk = ~clk;

    // Graphics data from a hash of the full address
    function automatic logic [31:0] rom_word(input logic [`OBJ_ROM_AW-1:0] a);
        logic [31:0] h;
        h = (32'(a) + 32'd1) * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        // Transparent nibbles at positions that move with the address
        for (int i = 0; i < 8; i++) begin
            if (((i + int'(a)) % 4) == 0) begin
                h[4*i +: 4] = 4'h0;
            end
        end
        return h;
    endfunction

    // ROM with 1 to 4 cycles of latency and a one-cycle ok
    always @(negedge clk) begin
        rom_ok = 1'b0;
        if (rom_cs) begin
            if (rom_left == 0) begin
                rom_left = $urandom_range(4, 1);
                req_addr = rom_addr;
            end else begin
                // Address stays put while the request is open
                check_rom_addr(rom_addr, req_addr, "rom_addr during a ROM request");
            end
            rom_left--;
            if (rom_left == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr);
            end
        end else begin
            if (rom_left != 0) begin
                err_cnt++;
                $display("** Error at %0t: rom_cs dropped before rom_ok", $time);
            end
            rom_left = 0;
        end
    end

    // Video timing with 1000-cycle lines and 320 visible pixels
    always @(negedge clk) begin
        if (video_on) begin
            // pxl changed on the rising edge that saw these levels
            if (pxl_cen && lhbl && cap_cnt < VIS_PIXELS) begin
                cap[cap_cnt] = pxl;
                cap_cnt++;
            end
            hcnt    = (hcnt == LINE_CYCLES - 1) ? 0 : hcnt + 1;
            hstart  = hcnt == 0;
            pxl_cen = (hcnt % 2) == 1;
            lhbl    = hcnt >= 200 && hcnt < 840;
            if (hcnt == 0) begin
                vrender = vnext;
                vnext   = vnext + 9'd1;
                line_cnt++;
                cap_cnt = 0;
            end
        end
    end

    task automatic report_timeout(input string what);
        to_cnt++;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] exp,
            input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rom_addr(input logic [`OBJ_ROM_AW-1:0] got,
            input logic [`OBJ_ROM_AW-1:0] exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pixel(input obj_pkg::obj_pixel_t got,
            input obj_pkg::obj_pixel_t exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s got prio %0d pal %h color %h",
                     $time, what, got.prio, got.pal, got.color);
            $display("   expected prio %0d pal %h color %h", exp.prio, exp.pal, exp.color);
        end
    endtask

    task automatic cpu_write(input logic [7:0] addr, input logic [15:0] data);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        @(negedge clk);
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
        shadow[{cpu_bank, addr}] = data;
    endtask

    // Data shows one cycle after the select
    task automatic cpu_read(input logic [7:0] addr, output logic [15:0] data);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_addr = addr;
        @(negedge clk);
        cpu_cs = 1'b0;
        data   = cpu_din;
    endtask

    task automatic swap_banks();
        @(negedge clk);
        obj_swap = 1'b1;
        @(negedge clk);
        obj_swap = 1'b0;
        cpu_bank = ~cpu_bank;
    endtask

    task automatic write_obj(input int entry, input logic [7:0] top,
            input logic [7:0] height, input logic [8:0] xpos, input logic [3:0] pal,
            input logic [1:0] prio, input logic hflip, input logic [15:0] base);
        logic [7:0] a;
        a = 8'(entry * 4);
        cpu_write(a, {top, height});
        cpu_write(a + 8'd1, {hflip, prio, pal, xpos});
        cpu_write(a + 8'd2, base);
        cpu_write(a + 8'd3, 16'h0000);
    endtask

    // Zero height ends the list
    task automatic end_list(input int entry);
        cpu_write(8'(entry * 4), 16'h0000);
    endtask

    // Expected line from the displayed bank
    function automatic void build_expected(input logic [8:0] v);
        logic [15:0]            w0;
        logic [15:0]            w1;
        logic [15:0]            w2;
        logic [8:0]             row;
        logic [`OBJ_ROM_AW-1:0] addr;
        logic [31:0]            gw;
        logic [3:0]             c;
        logic [8:0]             x;
        for (int k = 0; k < 512; k++) begin
            exp_line[k] = '0;
        end
        for (int e = 0; e < `OBJ_COUNT; e++) begin
            w0 = shadow[{~cpu_bank, 8'(4 * e)}];
            if (w0[7:0] == 8'd0) begin
                break;
            end
            row = v - {1'b0, w0[15:8]};
            if (row < {1'b0, w0[7:0]}) begin
                w1 = shadow[{~cpu_bank, 8'(4 * e + 1)}];
                w2 = shadow[{~cpu_bank, 8'(4 * e + 2)}];
                for (int i = 0; i < `OBJ_WIDTH; i++) begin
                    addr = `OBJ_ROM_AW'(w2) + `OBJ_ROM_AW'(2 * row) + `OBJ_ROM_AW'(i / 8);
                    gw   = rom_word(addr);
                    c    = gw[31 - 4 * (i % 8) -: 4];
                    // Mirror inside the 16 pixels and wrap at 512
                    x    = w1[8:0] + 9'(w1[15] ? 15 - i : i);
                    if (c != 4'd0) begin
                        exp_line[x] = {w1[14:13], w1[12:9], c};
                    end
                end
            end
        end
    endfunction

    task automatic wait_lines(input int n);
        int target;
        int cycles;
        target = line_cnt + n;
        cycles = 0;
        while (line_cnt < target && cycles < (n + 1) * LINE_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (line_cnt < target) begin
            report_timeout("the next video line");
        end
    endtask

    // Scan line v and check the pixels read on the line after
    task automatic run_line(input logic [8:0] v);
        int cycles;
        cycles = 0;
        // Start mid-line far from hstart
        while (hcnt != 500 && cycles < 2 * LINE_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (hcnt != 500) begin
            report_timeout("the middle of a line");
        end
        vnext = v;
        wait_lines(2);
        cycles = 0;
        while (cap_cnt < VIS_PIXELS && cycles < 2 * LINE_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (cap_cnt < VIS_PIXELS) begin
            report_timeout("320 visible pixels");
        end
        build_expected(v);
        for (int k = 0; k < VIS_PIXELS; k++) begin
            check_pixel(cap[k], exp_line[k], $sformatf("line %0d pixel %0d", v, k));
        end
    endtask

    task automatic bank_access();
        logic [15:0] rd;
        cpu_write(8'h21, 16'h1234);
        cpu_write(8'h22, 16'hbeef);
        cpu_read(8'h21, rd);
        check_word(rd, 16'h1234, "bank 0 word 21");
        cpu_read(8'h22, rd);
        check_word(rd, 16'hbeef, "bank 0 word 22");
        swap_banks();
        // Other bank still cleared
        cpu_read(8'h21, rd);
        check_word(rd, 16'h0000, "bank 1 word 21 before write");
        cpu_write(8'h21, 16'h5678);
        cpu_read(8'h21, rd);
        check_word(rd, 16'h5678, "bank 1 word 21");
        swap_banks();
        cpu_read(8'h21, rd);
        check_word(rd, 16'h1234, "bank 0 word 21 after two swaps");
    endtask

    task automatic single_object();
        write_obj(0, 8'd40, 8'd16, 9'd100, 4'h5, 2'd2, 1'b0, 16'h0100);
        end_list(1);
        swap_banks();
        run_line(9'd45);
        // CPU bank write leaves the displayed line unchanged
        write_obj(0, 8'd40, 8'd16, 9'd200, 4'ha, 2'd1, 1'b0, 16'h0400);
        end_list(1);
        run_line(9'd45);
    endtask

    task automatic hflip_mirror();
        write_obj(0, 8'd40, 8'd16, 9'd100, 4'h5, 2'd2, 1'b1, 16'h0100);
        end_list(1);
        swap_banks();
        run_line(9'd45);
    endtask

    task automatic overlap_transparency();
        write_obj(0, 8'd60, 8'd16, 9'd120, 4'h2, 2'd1, 1'b0, 16'h0200);
        write_obj(1, 8'd60, 8'd16, 9'd128, 4'h9, 2'd3, 1'b1, 16'h0300);
        end_list(2);
        swap_banks();
        run_line(9'd62);
        run_line(9'd75);
    endtask

    task automatic vertical_range();
        write_obj(0, 8'd80, 8'd8, 9'd50, 4'h3, 2'd1, 1'b0, 16'h0800);
        end_list(1);
        // Entry past the end marker covering the same lines
        write_obj(2, 8'd78, 8'd8, 9'd200, 4'h7, 2'd3, 1'b0, 16'h0900);
        swap_banks();
        run_line(9'd79);
        run_line(9'd80);
        run_line(9'd84);
        run_line(9'd87);
        run_line(9'd88);
    endtask

    task automatic erase_on_read();
        end_list(0);
        swap_banks();
        run_line(9'd84);
        run_line(9'd62);
    endtask

    initial begin
        void'($urandom(32'h6e62_092f));
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        // Both banks to zero
        for (int a = 0; a < 256; a++) begin
            cpu_write(8'(a), 16'h0000);
        end
        swap_banks();
        for (int a = 0; a < 256; a++) begin
            cpu_write(8'(a), 16'h0000);
        end
        swap_banks();
        video_on = 1'b1;
        // Read both buffer halves once so unknowns get erased
        wait_lines(3);
        bank_access();
        single_object();
        hflip_mirror();
        overlap_transparency();
        vertical_range();
        erase_on_read();
        $display("Errors: %0d, timeouts: %0d", err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/obj_pkg.sv
design/obj_draw_if.sv
design/obj_table_ram.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_line_buffer.sv
design/obj_engine.sv
tests/obj_engine_tb.sv

// File: Bender.yml
package:
  name: obj_engine

sources:
  - include_dirs:
      - design
    files:
      - design/obj_pkg.sv
      - design/obj_draw_if.sv
      - design/obj_table_ram.sv
      - design/obj_scan.sv
      - design/obj_draw.sv
      - design/obj_line_buffer.sv
      - design/obj_engine.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/obj_engine_tb.sv
